// ==== Makefile ====
# verilator build, run and lint of the mips core testbench

TOP := mips_core_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

obj_dir/V$(TOP): mips_core.f $(wildcard verilog/*.sv bench/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mips_core.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f mips_core.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/mips_cases.txt ====
// number of tests, then per test: name (4 ascii chars), program word count, program words,
// data pair count, (byte address, data) pairs, store count, (byte address, data) pairs, halt flag
00000006
// alu_: each r-type and i-type operation stored once
616c755f 00000022
2408fffb 340900f0 01095021 ac0a0100 01285823 ac0b0104 01096024 ac0c0108
01096827 ac0d010c 01097026 ac0e0110 01097825 ac0f0114 0109802a ac100118
0109882b ac11011c 3c128001 ac120120 00129903 ac130124 0012a202 ac140128
0009ae00 ac15012c 2916fffc ac160130 3117ff0f ac170134 39188000 ac180138
2402000a 0000000c
00000000
0000000f
00000100 000000eb 00000104 000000f5 00000108 000000f0 0000010c 00000004
00000110 ffffff0b 00000114 fffffffb 00000118 00000001 0000011c 00000000
00000120 80010000 00000124 f8001000 00000128 00800100 0000012c f0000000
00000130 00000001 00000134 0000ff0b 00000138 ffff7ffb
00000001
// fwd_: dependent chains, the nearer producer must win
6677645f 0000000d
24080003 01084821 01285021 01495823 ac0b0140 ac0a0144 240c0148 ad890000
240d0001 240d0002 ac0d014c 2402000a 0000000c
00000000
00000004
00000140 00000003 00000144 00000009 00000148 00000006 0000014c 00000002
00000001
// ldus: load followed right away by a use on rs and on store data
6c647573 00000008
8c080180 01084821 ac090188 8c0a0184 8d4b0180 ac0b018c 2402000a 0000000c
00000003
00000180 11223344 00000184 00000010 00000190 cafef00d
00000002
00000188 22446688 0000018c cafef00d
00000001
// brch: taken and not taken beq and bne, then a forward j
62726368 00000012
24080001 24090001 11090002 ac0801c0 ac0801c4 15090001 ac0901c8 15000002
ac0801cc ac0801d0 11000001 240a0007 0810000f ac0a01d4 ac0a01d8 ac0a01dc
2402000a 0000000c
00000000
00000002
000001c8 00000001 000001dc 00000007
00000001
// sysc: syscall with v0 = 4 runs on, v0 = 10 halts before two stores
73797363 00000008
24020004 0000000c 24080055 ac0801e0 2402000a 0000000c ac0801e4 ac0801e8
00000000
00000001
000001e0 00000055
00000001
// loop: non-halting syscall, one store, then a jump to itself
6c6f6f70 00000004
24020004 0000000c ac0201f0 08100003
00000000
00000001
000001f0 00000004
00000000

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ns
// testbench for the five-stage mips core
// loads each program of the cases file, resets the core,
// runs it to halt and lets the store checker grade it
module mips_core_tb;
   import mips_pkg::*;

   localparam word_t text_start = 32'h0040_0000;
   // upper bound on the run of one program
   localparam int    max_cycles = 400;

   logic   clk;
   logic   rst_b;
   waddr_t inst_addr;
   word_t  inst = '0;
   waddr_t mem_addr;
   word_t  mem_wdata;
   logic   mem_we;
   word_t  mem_rdata = '0;
   logic   halted;

   // flat image of the cases file and a read pointer into it
   word_t  case_words [1024];
   int     ptr;
   word_t  imem [256];
   // data image for the next test, copied into dmem during reset
   word_t  dinit [1024];
   word_t  dmem [1024];
   // expectations handed to the checker
   word_t  exp_addr [32];
   word_t  exp_data [32];
   int     exp_count;
   word_t  test_name;
   logic   halt_expect;
   logic   test_done;
   int     pass_count;
   int     fail_count;
   int     setup_errors;

   mips_core #(.text_start(text_start)) dut (.*);
   mips_store_checker chk (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // program words sit from text_start on, everything else is a nop
   function automatic word_t fetch_word(input waddr_t addr);
      waddr_t offs;
      offs = addr - text_start[31:2];
      if (offs < 30'd256) begin
         return imem[offs[7:0]];
      end
      return '0;
   endfunction

   // memories answer on the falling edge, after the address has settled
   always @(negedge clk) begin
      inst      <= fetch_word(inst_addr);
      mem_rdata <= dmem[mem_addr[9:0]];
   end

   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < 1024; i++) begin
            dmem[i] <= dinit[i];
         end
      end else if (mem_we) begin
         dmem[mem_addr[9:0]] <= mem_wdata;
      end
   end

   // one test: name, program, data pairs, store pairs, halt flag
   task automatic run_case();
      int    n_prog;
      int    n_data;
      int    cycles;
      word_t addr;
      @(negedge clk);
      rst_b     = 1'b0;
      test_name = case_words[ptr];
      n_prog    = case_words[ptr + 1];
      ptr       += 2;
      for (int i = 0; i < 256; i++) begin
         imem[i] = (i < n_prog) ? case_words[ptr + i] : '0;
      end
      ptr += n_prog;
      // unused data words hold noise
      for (int i = 0; i < 1024; i++) begin
         dinit[i] = $urandom;
      end
      n_data = case_words[ptr];
      ptr++;
      for (int i = 0; i < n_data; i++) begin
         addr = case_words[ptr + 2 * i];
         dinit[addr[11:2]] = case_words[ptr + 2 * i + 1];
      end
      ptr += 2 * n_data;
      exp_count = case_words[ptr];
      ptr++;
      for (int i = 0; i < exp_count; i++) begin
         exp_addr[i] = case_words[ptr + 2 * i];
         exp_data[i] = case_words[ptr + 2 * i + 1];
      end
      ptr += 2 * exp_count;
      halt_expect = case_words[ptr][0];
      ptr++;
      repeat (2) @(negedge clk);
      rst_b  = 1'b1;
      cycles = 0;
      while (!halted && cycles < max_cycles) begin
         @(negedge clk);
         cycles++;
      end
      // a short window in which no store may show up any more
      repeat (4) @(negedge clk);
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
   endtask

   initial begin
      int n_tests;
      void'($urandom(86036));
      rst_b        = 1'b0;
      test_done    = 1'b0;
      halt_expect  = 1'b0;
      test_name    = '0;
      exp_count    = 0;
      setup_errors = 0;
      for (int i = 0; i < 32; i++) begin
         exp_addr[i] = '0;
         exp_data[i] = '0;
      end
      $readmemh("bench/mips_cases.txt", case_words);
      n_tests = case_words[0];
      ptr     = 1;
      if (n_tests < 1 || n_tests > 16) begin
         $display("cases file holds no usable test count");
         setup_errors++;
      end else begin
         for (int t = 0; t < n_tests; t++) begin
            run_case();
         end
      end
      $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
      if (fail_count == 0 && setup_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== bench/mips_store_checker.sv ====
`timescale 1ns/1ns
// store checker for the mips core testbench
// compares every data port write with the expected stream,
// grades the halt at the end of a test and keeps the counts
module mips_store_checker (
   input  logic             clk,
   input  logic             rst_b,
   input  mips_pkg::waddr_t mem_addr,
   input  mips_pkg::word_t  mem_wdata,
   input  logic             mem_we,
   input  logic             halted,
   input  mips_pkg::word_t  test_name,
   input  mips_pkg::word_t  exp_addr [32],
   input  mips_pkg::word_t  exp_data [32],
   input  int               exp_count,
   input  logic             halt_expect,
   input  logic             test_done,
   output int               pass_count,
   output int               fail_count
);
   import mips_pkg::*;

   // stores seen and errors found in the running test
   int seen;
   int errors;
   int n_pass = 0;
   int n_fail = 0;

   assign pass_count = n_pass;
   assign fail_count = n_fail;

   // mem_we is a write strobe, so look at it where the memory does
   always @(posedge clk) begin
      int bad;
      int total;
      bad   = 0;
      total = 0;
      if (!rst_b) begin
         seen   <= 0;
         errors <= 0;
      end else begin
         if (mem_we && halted) begin
            $display("test %s: store issued while halted", test_name);
            bad++;
         end
         if (mem_we) begin
            if (seen >= exp_count) begin
               $display("test %s: extra store of %h to word address %h",
                        test_name, mem_wdata, mem_addr);
               bad++;
            end else begin
               if (mem_addr !== exp_addr[seen][31:2]) begin
                  $display("mismatch mem_addr in test %s store %0d: got %h, expected %h",
                           test_name, seen, mem_addr, exp_addr[seen][31:2]);
                  bad++;
               end
               if (mem_wdata !== exp_data[seen]) begin
                  $display("mismatch mem_wdata in test %s store %0d: got %h, expected %h",
                           test_name, seen, mem_wdata, exp_data[seen]);
                  bad++;
               end
            end
            seen <= seen + 1;
         end
         errors <= errors + bad;
         // end of test, grade what is still outstanding
         if (test_done) begin
            total = errors + bad;
            if (seen < exp_count) begin
               $display("test %s: missing stores, only %0d of %0d seen",
                        test_name, seen, exp_count);
               total++;
            end
            if (halt_expect && !halted) begin
               $display("test %s: timed out, the core never halted", test_name);
               total++;
            end
            if (!halt_expect && halted) begin
               $display("test %s: the core halted although it should keep running",
                        test_name);
               total++;
            end
            if (total == 0) begin
               $display("test %s: ok, %0d stores", test_name, seen);
               n_pass <= n_pass + 1;
            end else begin
               $display("test %s: %0d errors", test_name, total);
               n_fail <= n_fail + 1;
            end
         end
      end
   end

endmodule

// ==== mips_core.f ====
verilog/mips_pkg.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_regfile.sv
verilog/mips_execute.sv
verilog/mips_hazard.sv
verilog/mips_memwb.sv
verilog/mips_core.sv
bench/mips_store_checker.sv
bench/mips_core_tb.sv

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ns
// five-stage in-order mips core
// fetch, decode, execute, memory and writeback with separate
// instruction and data word ports
module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic             clk,
   input  logic             rst_b,
   output mips_pkg::waddr_t inst_addr,
   input  mips_pkg::word_t  inst,
   output mips_pkg::waddr_t mem_addr,
   output mips_pkg::word_t  mem_wdata,
   output logic             mem_we,
   input  mips_pkg::word_t  mem_rdata,
   output logic             halted
);
   import mips_pkg::*;

   // fetch to decode
   word_t       pc_id;
   word_t       inst_id;
   // decode outputs
   reg_idx_t    rs;
   reg_idx_t    rt_read;
   reg_idx_t    dest;
   word_t       imm;
   alu_op_t     alu_op;
   logic        use_imm;
   logic        reg_we;
   logic        is_load;
   logic        is_store;
   logic        is_beq;
   logic        is_bne;
   logic        is_jump;
   logic        is_sys;
   logic [25:0] target;
   word_t       rs_data;
   word_t       rt_data;
   // execute outputs
   word_t       ex_result;
   word_t       ex_store_data;
   reg_idx_t    ex_dest;
   logic        ex_reg_we;
   logic        ex_is_load;
   logic        ex_is_store;
   logic        ex_is_sys;
   logic        redirect;
   word_t       redirect_pc;
   // memory and writeback
   reg_idx_t    mem_dest;
   logic        mem_reg_we;
   word_t       mem_result;
   logic        wb_we;
   reg_idx_t    wb_reg;
   word_t       wb_data;
   // hazard unit
   logic        stall;
   logic        flush;
   fwd_sel_t    fwd_a;
   fwd_sel_t    fwd_b;

   // rt is a true source for r-type, branches, stores and syscall
   wire use_rt = !use_imm || is_store;

   mips_fetch #(.text_start(text_start)) u_fetch (.*);
   mips_decode u_decode (.*);
   mips_regfile u_regfile (.rt(rt_read), .*);
   mips_execute u_execute (.*);
   mips_hazard u_hazard (.*);
   mips_memwb u_memwb (.*);

endmodule

// ==== verilog/mips_decode.sv ====
`timescale 1ns/1ns
// decode stage of the mips core
// splits the instruction word, extends the immediate and
// produces the control bits; anything unknown is a no-op
module mips_decode (
   input  mips_pkg::word_t    inst_id,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt_read,
   output mips_pkg::reg_idx_t dest,
   output mips_pkg::word_t    imm,
   output mips_pkg::alu_op_t  alu_op,
   output logic               use_imm,
   output logic               reg_we,
   output logic               is_load,
   output logic               is_store,
   output logic               is_beq,
   output logic               is_bne,
   output logic               is_jump,
   output logic               is_sys,
   output logic [25:0]        target
);
   import mips_pkg::*;

   logic [5:0] op;
   logic [5:0] funct;
   reg_idx_t   rt;
   logic       zero_ext;

   assign op     = inst_id[31:26];
   assign funct  = inst_id[5:0];
   assign rs     = inst_id[25:21];
   assign rt     = inst_id[20:16];
   assign target = inst_id[25:0];

   // syscall reads $v0 through the rt port so the code rides to writeback
   assign rt_read = is_sys ? reg_v0 : rt;
   // r-type writes rd, i-type writes rt
   assign dest = (op == op_special) ? inst_id[15:11] : rt;

   // logical immediates are zero extended, the rest sign extended
   assign zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);
   assign imm = zero_ext ? {16'h0, inst_id[15:0]} : {{16{inst_id[15]}}, inst_id[15:0]};

   always_comb begin
      alu_op   = alu_add;
      use_imm  = 1'b0;
      reg_we   = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_beq   = 1'b0;
      is_bne   = 1'b0;
      is_jump  = 1'b0;
      is_sys   = 1'b0;
      case (op)
         op_special: begin
            reg_we = 1'b1;
            case (funct)
               fn_sll:  alu_op = alu_sll;
               fn_srl:  alu_op = alu_srl;
               fn_sra:  alu_op = alu_sra;
               fn_addu: alu_op = alu_add;
               fn_subu: alu_op = alu_sub;
               fn_and:  alu_op = alu_and;
               fn_or:   alu_op = alu_or;
               fn_xor:  alu_op = alu_xor;
               fn_nor:  alu_op = alu_nor;
               fn_slt:  alu_op = alu_slt;
               fn_sltu: alu_op = alu_sltu;
               fn_syscall: begin
                  reg_we = 1'b0;
                  is_sys = 1'b1;
               end
               default: reg_we = 1'b0;
            endcase
         end
         op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
            case (op)
               op_slti: alu_op = alu_slt;
               op_andi: alu_op = alu_and;
               op_ori:  alu_op = alu_or;
               op_xori: alu_op = alu_xor;
               op_lui:  alu_op = alu_lui;
               default: alu_op = alu_add;
            endcase
         end
         op_lw: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
            is_load = 1'b1;
         end
         // store address is rs + offset, data comes from rt
         op_sw: begin
            use_imm  = 1'b1;
            is_store = 1'b1;
         end
         op_beq: is_beq = 1'b1;
         op_bne: is_bne = 1'b1;
         op_j:   is_jump = 1'b1;
         default: ;
      endcase
   end

endmodule

// ==== verilog/mips_execute.sv ====
`timescale 1ns/1ns
// execute stage of the mips core
// decode/execute register, operand forwarding, the alu and
// resolution of beq, bne and j into a pc redirect
module mips_execute (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               stall,
   input  logic               flush,
   input  mips_pkg::reg_idx_t dest,
   input  mips_pkg::word_t    imm,
   input  mips_pkg::alu_op_t  alu_op,
   input  logic               use_imm,
   input  logic               reg_we,
   input  logic               is_load,
   input  logic               is_store,
   input  logic               is_beq,
   input  logic               is_bne,
   input  logic               is_jump,
   input  logic               is_sys,
   input  logic [25:0]        target,
   input  mips_pkg::word_t    rs_data,
   input  mips_pkg::word_t    rt_data,
   input  mips_pkg::fwd_sel_t fwd_a,
   input  mips_pkg::fwd_sel_t fwd_b,
   input  mips_pkg::word_t    mem_result,
   input  mips_pkg::word_t    wb_data,
   input  mips_pkg::word_t    pc_id,
   output mips_pkg::word_t    ex_result,
   output mips_pkg::word_t    ex_store_data,
   output mips_pkg::reg_idx_t ex_dest,
   output logic               ex_reg_we,
   output logic               ex_is_load,
   output logic               ex_is_store,
   output logic               ex_is_sys,
   output logic               redirect,
   output mips_pkg::word_t    redirect_pc
);
   import mips_pkg::*;

   word_t       pc_ex;
   word_t       rs_ex;
   word_t       rt_ex;
   word_t       imm_ex;
   logic [25:0] target_ex;
   alu_op_t     alu_op_ex;
   logic        use_imm_ex;
   fwd_sel_t    fwd_a_ex;
   fwd_sel_t    fwd_b_ex;
   logic        beq_ex;
   logic        bne_ex;
   logic        jump_ex;
   word_t       op_a;
   word_t       op_b_reg;
   word_t       op_b;
   word_t       alu_out;
   word_t       seq_pc;
   logic [4:0]  shamt;

   // controls go to zero on a bubble, payload just follows
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_reg_we   <= 1'b0;
         ex_is_load  <= 1'b0;
         ex_is_store <= 1'b0;
         ex_is_sys   <= 1'b0;
         beq_ex      <= 1'b0;
         bne_ex      <= 1'b0;
         jump_ex     <= 1'b0;
      end else if (stall || flush) begin
         ex_reg_we   <= 1'b0;
         ex_is_load  <= 1'b0;
         ex_is_store <= 1'b0;
         ex_is_sys   <= 1'b0;
         beq_ex      <= 1'b0;
         bne_ex      <= 1'b0;
         jump_ex     <= 1'b0;
      end else begin
         ex_reg_we   <= reg_we;
         ex_is_load  <= is_load;
         ex_is_store <= is_store;
         ex_is_sys   <= is_sys;
         beq_ex      <= is_beq;
         bne_ex      <= is_bne;
         jump_ex     <= is_jump;
      end
   end

   always_ff @(posedge clk) begin
      pc_ex      <= pc_id;
      rs_ex      <= rs_data;
      rt_ex      <= rt_data;
      imm_ex     <= imm;
      target_ex  <= target;
      ex_dest    <= dest;
      alu_op_ex  <= alu_op;
      use_imm_ex <= use_imm;
      fwd_a_ex   <= fwd_a;
      fwd_b_ex   <= fwd_b;
   end

   function automatic word_t pick(input fwd_sel_t sel, input word_t rf_val);
      case (sel)
         fwd_mem: return mem_result;
         fwd_wb:  return wb_data;
         default: return rf_val;
      endcase
   endfunction

   always_comb begin
      op_a     = pick(fwd_a_ex, rs_ex);
      op_b_reg = pick(fwd_b_ex, rt_ex);
   end

   assign op_b  = use_imm_ex ? imm_ex : op_b_reg;
   // shamt sits in bits 10:6 of the extended immediate
   assign shamt = imm_ex[10:6];

   always_comb begin
      case (alu_op_ex)
         alu_sub:  alu_out = op_a - op_b;
         alu_and:  alu_out = op_a & op_b;
         alu_or:   alu_out = op_a | op_b;
         alu_xor:  alu_out = op_a ^ op_b;
         alu_nor:  alu_out = ~(op_a | op_b);
         alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         alu_sltu: alu_out = {31'b0, op_a < op_b};
         alu_sll:  alu_out = op_b << shamt;
         alu_srl:  alu_out = op_b >> shamt;
         alu_sra:  alu_out = word_t'($signed(op_b) >>> shamt);
         alu_lui:  alu_out = {op_b[15:0], 16'h0};
         default:  alu_out = op_a + op_b;
      endcase
   end

   // syscall carries $v0 down the result path for the halt check
   assign ex_result     = ex_is_sys ? op_b_reg : alu_out;
   assign ex_store_data = op_b_reg;

   assign seq_pc   = pc_ex + 32'd4;
   assign redirect = jump_ex || (beq_ex && op_a == op_b_reg) || (bne_ex && op_a != op_b_reg);
   assign redirect_pc = jump_ex ? {seq_pc[31:28], target_ex, 2'b00}
                                : seq_pc + {imm_ex[29:0], 2'b00};

   // the slot behind a taken branch or jump is flushed and never redirects
   assert property (@(posedge clk) disable iff (!rst_b) redirect |=> !redirect)
      else $error("redirect raised by a bubble in execute");

endmodule

// ==== verilog/mips_fetch.sv ====
`timescale 1ns/1ns
// fetch stage of the mips core
// owns the pc and the fetch/decode register, and applies
// redirects, load-use holds, flushes and the halt freeze
module mips_fetch #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic             clk,
   input  logic             rst_b,
   input  logic             stall,
   input  logic             flush,
   input  logic             halted,
   input  logic             redirect,
   input  mips_pkg::word_t  redirect_pc,
   input  mips_pkg::word_t  inst,
   output mips_pkg::waddr_t inst_addr,
   output mips_pkg::word_t  pc_id,
   output mips_pkg::word_t  inst_id
);
   import mips_pkg::*;

   word_t pc;

   assign inst_addr = pc[31:2];

   // halt freezes everything, a redirect beats the sequential step
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= text_start;
      end else if (!halted) begin
         if (redirect) begin
            pc <= redirect_pc;
         end else if (!stall) begin
            pc <= pc + 32'd4;
         end
      end
   end

   // a zero word is sll $0,$0,0, which is a no-op
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_id <= '0;
      end else if (flush) begin
         inst_id <= '0;
      end else if (!stall && !halted) begin
         inst_id <= inst;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && !halted) begin
         pc_id <= pc;
      end
   end

   // redirect targets come from execute and must stay aligned
   assert property (@(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00)
      else $error("pc not word aligned: %h", pc);

endmodule

// ==== verilog/mips_hazard.sv ====
`timescale 1ns/1ns
// hazard unit of the mips core
// picks operand forwarding for the instruction in decode,
// detects load-use stalls and flushes on a redirect
module mips_hazard (
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt_read,
   input  logic               use_rt,
   input  mips_pkg::reg_idx_t ex_dest,
   input  logic               ex_reg_we,
   input  logic               ex_is_load,
   input  mips_pkg::reg_idx_t mem_dest,
   input  logic               mem_reg_we,
   input  mips_pkg::reg_idx_t wb_reg,
   input  logic               wb_we,
   input  logic               redirect,
   output logic               stall,
   output logic               flush,
   output mips_pkg::fwd_sel_t fwd_a,
   output mips_pkg::fwd_sel_t fwd_b
);
   import mips_pkg::*;

   // selects are registered with the operand, so a producer now in
   // execute will be in memory when the consumer executes
   function automatic fwd_sel_t select(input reg_idx_t src);
      if (src == reg_zero) begin
         return fwd_rf;
      end else if (ex_reg_we && ex_dest == src) begin
         return fwd_mem;
      end else if (mem_reg_we && mem_dest == src) begin
         return fwd_wb;
      end
      // a producer now in writeback reaches decode through the regfile write-through
      return fwd_rf;
   endfunction

   always_comb begin
      fwd_a = select(rs);
      fwd_b = select(rt_read);
   end

   // load data only exists from memory onward, so hold one cycle
   assign stall = ex_is_load && ex_reg_we && ex_dest != reg_zero &&
                  (ex_dest == rs || (use_rt && ex_dest == rt_read));
   assign flush = redirect;

   // a load and a branch never share the execute stage
   always_comb begin
      assert final (!(stall && flush))
         else $error("stall and flush raised together");
   end

endmodule

// ==== verilog/mips_memwb.sv ====
`timescale 1ns/1ns
// memory and writeback stages of the mips core
// drives the data port, picks load data or alu result for
// writeback and latches the syscall halt
module mips_memwb (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::word_t    ex_result,
   input  mips_pkg::word_t    ex_store_data,
   input  mips_pkg::reg_idx_t ex_dest,
   input  logic               ex_reg_we,
   input  logic               ex_is_load,
   input  logic               ex_is_store,
   input  logic               ex_is_sys,
   output mips_pkg::waddr_t   mem_addr,
   output mips_pkg::word_t    mem_wdata,
   output logic               mem_we,
   input  mips_pkg::word_t    mem_rdata,
   output mips_pkg::reg_idx_t mem_dest,
   output logic               mem_reg_we,
   output mips_pkg::word_t    mem_result,
   output logic               wb_we,
   output mips_pkg::reg_idx_t wb_reg,
   output mips_pkg::word_t    wb_data,
   output logic               halted
);
   import mips_pkg::*;

   word_t alu_mem;
   logic  load_mem;
   logic  store_mem;
   logic  sys_mem;
   logic  we_wb;
   logic  sys_wb;
   logic  halt_now;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_reg_we <= 1'b0;
         load_mem   <= 1'b0;
         store_mem  <= 1'b0;
         sys_mem    <= 1'b0;
         we_wb      <= 1'b0;
         sys_wb     <= 1'b0;
         halted     <= 1'b0;
      end else begin
         mem_reg_we <= ex_reg_we;
         load_mem   <= ex_is_load;
         store_mem  <= ex_is_store;
         sys_mem    <= ex_is_sys;
         we_wb      <= mem_reg_we;
         sys_wb     <= sys_mem;
         if (halt_now) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      alu_mem   <= ex_result;
      mem_wdata <= ex_store_data;
      mem_dest  <= ex_dest;
      wb_data   <= mem_result;
      wb_reg    <= mem_dest;
   end

   assign mem_addr   = alu_mem[31:2];
   assign mem_result = load_mem ? mem_rdata : alu_mem;

   // for a syscall wb_data holds the $v0 it read
   assign halt_now = sys_wb && wb_data == halt_code;
   // the store right behind a halting syscall is already in memory
   assign mem_we = store_mem && !halted && !halt_now;
   assign wb_we  = we_wb && !halted;

   // a syscall only carries $v0, never a data access or a register write
   assert property (@(posedge clk) disable iff (!rst_b)
                    sys_mem |-> !store_mem && !load_mem && !mem_reg_we)
      else $error("syscall in memory with a data access or register write");

endmodule

// ==== verilog/mips_pkg.sv ====
// shared definitions for the five-stage mips core
// word and register-number types, instruction encodings
// and the enums used by the alu and the forwarding muxes
package mips_pkg;

   typedef logic [31:0] word_t;
   // word address as seen by both memory ports
   typedef logic [29:0] waddr_t;
   typedef logic [4:0]  reg_idx_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or,
      alu_xor, alu_nor, alu_slt, alu_sltu,
      alu_sll, alu_srl, alu_sra, alu_lui
   } alu_op_t;

   // operand source picked in execute
   typedef enum logic [1:0] {
      fwd_rf, fwd_mem, fwd_wb
   } fwd_sel_t;

   // primary opcodes
   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_j       = 6'h02;
   localparam logic [5:0] op_beq     = 6'h04;
   localparam logic [5:0] op_bne     = 6'h05;
   localparam logic [5:0] op_addiu   = 6'h09;
   localparam logic [5:0] op_slti    = 6'h0a;
   localparam logic [5:0] op_andi    = 6'h0c;
   localparam logic [5:0] op_ori     = 6'h0d;
   localparam logic [5:0] op_xori    = 6'h0e;
   localparam logic [5:0] op_lui     = 6'h0f;
   localparam logic [5:0] op_lw      = 6'h23;
   localparam logic [5:0] op_sw      = 6'h2b;

   // funct field of special
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;
   localparam logic [5:0] fn_nor     = 6'h27;
   localparam logic [5:0] fn_slt     = 6'h2a;
   localparam logic [5:0] fn_sltu    = 6'h2b;

   localparam reg_idx_t reg_zero  = 5'd0;
   localparam reg_idx_t reg_v0    = 5'd2;
   // exit code in $v0
   localparam word_t    halt_code = 32'd10;

endpackage

// ==== verilog/mips_regfile.sv ====
`timescale 1ns/1ns
// 32-entry register file, two read ports and one write port
// a read of the register written this cycle sees the new value
module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data,
   input  logic               wb_we,
   input  mips_pkg::reg_idx_t wb_reg,
   input  mips_pkg::word_t    wb_data
);
   import mips_pkg::*;

   word_t regs [32];

   // cleared on reset so each program starts from zeroed registers
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we && wb_reg != reg_zero) begin
         regs[wb_reg] <= wb_data;
      end
   end

   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == reg_zero) begin
         return '0;
      end
      // bypass the same-cycle writeback
      if (wb_we && wb_reg == idx) begin
         return wb_data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs_data = read_port(rs);
      rt_data = read_port(rt);
   end

endmodule
